// ==== hw/cache_xfer_pkg.sv ====
/* Shared types and constants for the cache refill and writeback path.
   Every RTL block of the subsystem imports what it needs from here. */

package cache_xfer_pkg;

    // ---------------------------------------------------------------------
    // Widths.
    // ---------------------------------------------------------------------

    // One memory word per beat.
    localparam int unsigned BEAT_W = 32;

    // Word addressed backing memory.
    localparam int unsigned ADDR_W = 32;

    // Beat index, 0 to 15.
    localparam int unsigned CNT_W = 4;

    // Beats in one block, kept as one word.
    localparam logic [31:0] BEATS_PER_BLOCK = 32'd16;

    // Whole cache block.
    localparam int unsigned BLOCK_W = BEAT_W * BEATS_PER_BLOCK;

    // ---------------------------------------------------------------------
    // Types.
    // ---------------------------------------------------------------------
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [CNT_W-1:0]   beat_cnt_t;

    // Memory port arbiter FSM.
    typedef enum logic [1:0] {
        ARB_IDLE     = 2'd0,
        ARB_ACCESS   = 2'd1,
        ARB_WAIT_ACK = 2'd2
    } arb_state_t;

endpackage

// ==== hw/beat_sequencer.sv ====
/* Beat counter and beat address generator for one block transfer.
   Loaded by a start, stepped by each beat done, pulses done after beat 15. */

`timescale 1ns/1ps

module beat_sequencer (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_beat_done,
    input  cache_xfer_pkg::addr_t i_base_addr,
    output cache_xfer_pkg::addr_t o_beat_addr,
    output logic                  o_last,
    output logic                  o_done
);

    import cache_xfer_pkg::*;

    // Index of the final beat of a block.
    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS_PER_BLOCK - 32'd1);

    beat_cnt_t cnt_q;
    addr_t     addr_q;
    logic      done_q;

    // ---------------------------------------------------------------------
    // Beat counter.
    // ---------------------------------------------------------------------
    // Wraps back to 0 after the last beat.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_start) begin
            cnt_q <= '0;
        end else if (i_beat_done) begin
            cnt_q <= cnt_q + beat_cnt_t'(1);
        end
    end

    // Address of the current beat.
    // Consecutive words, starting at the base.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (i_start) begin
            addr_q <= i_base_addr;
        end else if (i_beat_done) begin
            addr_q <= addr_q + addr_t'(1);
        end
    end

    // Done follows the ack of the last beat by one cycle.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= i_beat_done & o_last;
        end
    end

    assign o_beat_addr = addr_q;
    assign o_last      = (cnt_q == LAST_BEAT);
    assign o_done      = done_q;

endmodule

// ==== hw/block_shift_buffer.sv ====
/* Block-wide shift register between the cache side and the beat port.
   Fills from the top word on reads, drains from the bottom word on writes. */

`timescale 1ns/1ps

module block_shift_buffer (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_load,
    input  logic                   i_shift,
    input  logic                   i_fill,
    input  cache_xfer_pkg::block_t i_block,
    input  cache_xfer_pkg::beat_t  i_beat,
    output cache_xfer_pkg::beat_t  o_beat,
    output cache_xfer_pkg::block_t o_block
);

    import cache_xfer_pkg::*;

    // Whole block, word 0 in the low bits.
    block_t blk_q;

    // Word entering at the top on a shift.
    beat_t  top_beat;

    // ---------------------------------------------------------------------
    // Incoming word.
    // ---------------------------------------------------------------------
    // Read data on a fill.
    // Zeros on a writeback, the upper words are spent by then.
    assign top_beat = i_fill ? i_beat : '0;

    // ---------------------------------------------------------------------
    // Shift register.
    // ---------------------------------------------------------------------
    // Load wins over shift, it marks a new writeback.
    // Each shift moves every word down by one.
    // After sixteen fill beats the first beat read sits in word 0.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            blk_q <= '0;
        end else if (i_load) begin
            blk_q <= i_block;
        end else if (i_shift) begin
            blk_q <= {top_beat, blk_q[BLOCK_W-1:BEAT_W]};
        end
    end

    // ---------------------------------------------------------------------
    // Outputs.
    // ---------------------------------------------------------------------
    // Next writeback beat.
    assign o_beat  = blk_q[BEAT_W-1:0];

    // Raw contents, moving during a fill.
    assign o_block = blk_q;

endmodule

// ==== hw/cache_data_transfer.sv ====
/* One cache-side transfer engine for block fills and writebacks.
   Joins a beat sequencer with a block shift buffer and tracks busy and direction. */

`timescale 1ns/1ps

module cache_data_transfer (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_start_read,
    input  logic                   i_start_write,
    input  cache_xfer_pkg::addr_t  i_addr,
    input  cache_xfer_pkg::block_t i_block,
    input  logic                   i_beat_done,
    input  cache_xfer_pkg::beat_t  i_beat_rdata,
    output logic                   o_busy,
    output logic                   o_write_dir,
    output cache_xfer_pkg::addr_t  o_beat_addr,
    output cache_xfer_pkg::beat_t  o_beat_wdata,
    output logic                   o_last,
    output cache_xfer_pkg::block_t o_block,
    output logic                   o_done
);

    import cache_xfer_pkg::*;

    logic   start_ok;
    logic   start_wr;
    logic   seq_last;
    logic   seq_done;
    logic   busy_q;
    logic   dir_q;
    logic   fill_done;
    block_t buf_block;
    block_t hold_q;

    // ---------------------------------------------------------------------
    // Start and direction.
    // ---------------------------------------------------------------------
    // Starts while busy are dropped.
    assign start_ok = (i_start_read | i_start_write) & ~busy_q;

    // Read takes precedence when both strobes are high.
    assign start_wr = start_ok & ~i_start_read;

    // Busy falls with the ack of the last beat.
    // So the arbiter sees it low once the grant is released.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            dir_q  <= 1'b0;
        end else if (start_ok) begin
            busy_q <= 1'b1;
            dir_q  <= ~i_start_read;
        end else if (i_beat_done & seq_last) begin
            busy_q <= 1'b0;
        end
    end

    // Lower-level blocks.
    beat_sequencer u_sequencer (
        .clk         ( clk          ),
        .i_rst_n     ( i_rst_n      ),
        .i_start     ( start_ok     ),
        .i_beat_done ( i_beat_done  ),
        .i_base_addr ( i_addr       ),
        .o_beat_addr ( o_beat_addr  ),
        .o_last      ( seq_last     ),
        .o_done      ( seq_done     )
    );

    block_shift_buffer u_buffer (
        .clk     ( clk          ),
        .i_rst_n ( i_rst_n      ),
        .i_load  ( start_wr     ),
        .i_shift ( i_beat_done  ),
        .i_fill  ( ~dir_q       ),
        .i_block ( i_block      ),
        .i_beat  ( i_beat_rdata ),
        .o_beat  ( o_beat_wdata ),
        .o_block ( buf_block    )
    );

    // ---------------------------------------------------------------------
    // Filled block.
    // ---------------------------------------------------------------------
    assign fill_done = seq_done & ~dir_q;

    // Last completed fill, kept while the next one shifts in.
    always_ff @(posedge clk) begin
        if (fill_done) begin
            hold_q <= buf_block;
        end
    end

    // Buffer is whole in the done cycle, the hold register after it.
    assign o_block     = fill_done ? buf_block : hold_q;
    assign o_busy      = busy_q;
    assign o_write_dir = dir_q;
    assign o_last      = seq_last;
    assign o_done      = seq_done;

endmodule

// ==== hw/mem_port_arbiter.sv ====
/* Round-robin arbiter for the shared beat memory port.
   Locks the port to one engine for a whole block and routes the acks back. */

`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_busy_a,
    input  logic                  i_busy_b,
    input  logic                  i_last_a,
    input  logic                  i_last_b,
    input  logic                  i_write_a,
    input  logic                  i_write_b,
    input  cache_xfer_pkg::addr_t i_addr_a,
    input  cache_xfer_pkg::addr_t i_addr_b,
    input  cache_xfer_pkg::beat_t i_wdata_a,
    input  cache_xfer_pkg::beat_t i_wdata_b,
    output logic                  o_beat_done_a,
    output logic                  o_beat_done_b,
    output cache_xfer_pkg::beat_t o_beat_rdata,
    output logic                  o_mem_en,
    output logic                  o_mem_we,
    output cache_xfer_pkg::addr_t o_mem_addr,
    output cache_xfer_pkg::beat_t o_mem_wdata,
    input  logic                  i_mem_ack,
    input  cache_xfer_pkg::beat_t i_mem_rdata
);

    import cache_xfer_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       grant_b_q;
    logic       last_b_q;
    logic       pick_b;
    logic       any_busy;
    logic       sel_last;
    logic       sel_write;
    addr_t      sel_addr;
    beat_t      sel_wdata;
    logic       beat_done;

    // ---------------------------------------------------------------------
    // Selection.
    // ---------------------------------------------------------------------
    assign any_busy = i_busy_a | i_busy_b;

    // B wins if alone, or if A was served last.
    assign pick_b = i_busy_b & (~i_busy_a | ~last_b_q);

    // Granted engine's beat.
    assign sel_last  = grant_b_q ? i_last_b  : i_last_a;
    assign sel_write = grant_b_q ? i_write_b : i_write_a;
    assign sel_addr  = grant_b_q ? i_addr_b  : i_addr_a;
    assign sel_wdata = grant_b_q ? i_wdata_b : i_wdata_a;

    // ---------------------------------------------------------------------
    // FSM.
    // ---------------------------------------------------------------------
    // One access in flight at a time.
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (any_busy) begin
                    state_d = ARB_ACCESS;
                end
            end
            ARB_ACCESS: begin
                state_d = ARB_WAIT_ACK;
            end
            ARB_WAIT_ACK: begin
                // Last beat of the engine frees the port.
                if (i_mem_ack) begin
                    state_d = sel_last ? ARB_IDLE : ARB_ACCESS;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    // Grant taken in idle, last-served noted on release.
    // After reset A has priority.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= ARB_IDLE;
            grant_b_q <= 1'b0;
            last_b_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            if ((state_q == ARB_IDLE) && any_busy) begin
                grant_b_q <= pick_b;
            end
            if (beat_done && sel_last) begin
                last_b_q <= grant_b_q;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Memory side and beat strobes.
    // ---------------------------------------------------------------------
    assign beat_done     = (state_q == ARB_WAIT_ACK) & i_mem_ack;
    assign o_beat_done_a = beat_done & ~grant_b_q;
    assign o_beat_done_b = beat_done & grant_b_q;
    assign o_beat_rdata  = i_mem_rdata;

    assign o_mem_en    = (state_q == ARB_ACCESS);
    assign o_mem_we    = o_mem_en & sel_write;
    assign o_mem_addr  = sel_addr;
    assign o_mem_wdata = sel_wdata;

endmodule

// ==== hw/beat_memory.sv ====
/* Single-port word memory behind the arbiter.
   Every enable is acked one cycle later, read data arrives with the ack. */

`timescale 1ns/1ps

module beat_memory #(
    parameter int unsigned MEM_DEPTH = 1024
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_en,
    input  logic                  i_we,
    input  cache_xfer_pkg::addr_t i_addr,
    input  cache_xfer_pkg::beat_t i_wdata,
    output logic                  o_ack,
    output cache_xfer_pkg::beat_t o_rdata
);

    import cache_xfer_pkg::*;

    // Low address bits index the array.
    localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

    beat_t            mem_q [MEM_DEPTH];
    beat_t            rdata_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;

    assign idx = i_addr[IDX_W-1:0];

    // ---------------------------------------------------------------------
    // Array and read register.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_en && i_we) begin
            mem_q[idx] <= i_wdata;
        end
        if (i_en && !i_we) begin
            rdata_q <= mem_q[idx];
        end
    end

    // Ack for reads and writes alike.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_en;
        end
    end

    assign o_ack   = ack_q;
    assign o_rdata = rdata_q;

endmodule

// ==== hw/refill_subsystem_top.sv ====
/* Cache refill and writeback subsystem.
   Engine A serves the instruction side, engine B the data side, one shared memory. */

`timescale 1ns/1ps

module refill_subsystem_top #(
    parameter int unsigned MEM_DEPTH = 1024
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    // Instruction side.
    input  logic                   i_start_read_a,
    input  logic                   i_start_write_a,
    input  cache_xfer_pkg::addr_t  i_addr_a,
    input  cache_xfer_pkg::block_t i_block_a,
    output cache_xfer_pkg::block_t o_block_a,
    output logic                   o_done_a,
    output logic                   o_busy_a,
    // Data side.
    input  logic                   i_start_read_b,
    input  logic                   i_start_write_b,
    input  cache_xfer_pkg::addr_t  i_addr_b,
    input  cache_xfer_pkg::block_t i_block_b,
    output cache_xfer_pkg::block_t o_block_b,
    output logic                   o_done_b,
    output logic                   o_busy_b
);

    import cache_xfer_pkg::*;

    // Engine to arbiter.
    logic  write_a, write_b;
    logic  last_a, last_b;
    addr_t beat_addr_a, beat_addr_b;
    beat_t wdata_a, wdata_b;
    logic  beat_done_a, beat_done_b;
    beat_t beat_rdata;

    // Arbiter to memory.
    logic  mem_en, mem_we, mem_ack;
    addr_t mem_addr;
    beat_t mem_wdata, mem_rdata;

    // ---------------------------------------------------------------------
    // Engines.
    // ---------------------------------------------------------------------
    cache_data_transfer u_engine_a (
        .clk (clk), .i_rst_n (i_rst_n),
        .i_start_read (i_start_read_a), .i_start_write (i_start_write_a),
        .i_addr (i_addr_a), .i_block (i_block_a),
        .i_beat_done (beat_done_a), .i_beat_rdata (beat_rdata),
        .o_busy (o_busy_a), .o_write_dir (write_a),
        .o_beat_addr (beat_addr_a), .o_beat_wdata (wdata_a),
        .o_last (last_a), .o_block (o_block_a), .o_done (o_done_a)
    );

    cache_data_transfer u_engine_b (
        .clk (clk), .i_rst_n (i_rst_n),
        .i_start_read (i_start_read_b), .i_start_write (i_start_write_b),
        .i_addr (i_addr_b), .i_block (i_block_b),
        .i_beat_done (beat_done_b), .i_beat_rdata (beat_rdata),
        .o_busy (o_busy_b), .o_write_dir (write_b),
        .o_beat_addr (beat_addr_b), .o_beat_wdata (wdata_b),
        .o_last (last_b), .o_block (o_block_b), .o_done (o_done_b)
    );

    // ---------------------------------------------------------------------
    // Shared port.
    // ---------------------------------------------------------------------
    mem_port_arbiter u_arbiter (
        .clk (clk), .i_rst_n (i_rst_n),
        .i_busy_a (o_busy_a), .i_busy_b (o_busy_b),
        .i_last_a (last_a), .i_last_b (last_b),
        .i_write_a (write_a), .i_write_b (write_b),
        .i_addr_a (beat_addr_a), .i_addr_b (beat_addr_b),
        .i_wdata_a (wdata_a), .i_wdata_b (wdata_b),
        .o_beat_done_a (beat_done_a), .o_beat_done_b (beat_done_b),
        .o_beat_rdata (beat_rdata),
        .o_mem_en (mem_en), .o_mem_we (mem_we),
        .o_mem_addr (mem_addr), .o_mem_wdata (mem_wdata),
        .i_mem_ack (mem_ack), .i_mem_rdata (mem_rdata)
    );

    beat_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_memory (
        .clk (clk), .i_rst_n (i_rst_n),
        .i_en (mem_en), .i_we (mem_we),
        .i_addr (mem_addr), .i_wdata (mem_wdata),
        .o_ack (mem_ack), .o_rdata (mem_rdata)
    );

endmodule

// ==== sim/refill_tb.sv ====
/* Self-checking testbench for the cache refill and writeback subsystem.
   Runs directed and random block transfers against a word-level reference memory. */

`timescale 1ns/1ps

module refill_tb;

    import cache_xfer_pkg::*;

    localparam int unsigned MEM_DEPTH      = 1024;
    // Start to done of a block that gets the port at once.
    localparam int          LAT_ALONE      = 34;
    // Loser of a tie is regranted the cycle after the winner's done.
    localparam int          LAT_SECOND     = LAT_ALONE + 33;
    localparam int          TIMEOUT_CYCLES = 40 * 80;

    logic        clk;
    logic        i_rst_n;
    logic        i_start_read_a;
    logic        i_start_write_a;
    addr_t       i_addr_a;
    block_t      i_block_a;
    block_t      o_block_a;
    logic        o_done_a;
    logic        o_busy_a;
    logic        i_start_read_b;
    logic        i_start_write_b;
    addr_t       i_addr_b;
    block_t      i_block_b;
    block_t      o_block_b;
    logic        o_done_b;
    logic        o_busy_b;

    // Reference memory and a written flag per block.
    beat_t       ref_mem [MEM_DEPTH];
    logic [63:0] ref_valid;
    logic [31:0] lfsr_state;
    // Engine served last.
    // Starts as B so that A has priority.
    logic        last_b;
    int          cycle_cnt;

    refill_subsystem_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_dut (
        .clk (clk), .i_rst_n (i_rst_n),
        .i_start_read_a (i_start_read_a), .i_start_write_a (i_start_write_a),
        .i_addr_a (i_addr_a), .i_block_a (i_block_a),
        .o_block_a (o_block_a), .o_done_a (o_done_a), .o_busy_a (o_busy_a),
        .i_start_read_b (i_start_read_b), .i_start_write_b (i_start_write_b),
        .i_addr_b (i_addr_b), .i_block_b (i_block_b),
        .o_block_b (o_block_b), .o_done_b (o_done_b), .o_busy_b (o_busy_b)
    );

    always #5 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
            $display("sim failed");
            $fatal(1, "run aborted by the cycle limit");
        end
    end

    // ---------------------------------------------------------------------
    // Helpers.
    // ---------------------------------------------------------------------
    // Galois LFSR shifting right.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit.
    task automatic take_bits(input int cnt, output block_t v);
        v = '0;
        for (int i = 0; i < cnt; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    // Expected block with word i from address base plus i.
    function automatic block_t ref_block(input addr_t base);
        block_t blk;
        addr_t  a;
        for (int i = 0; i < 16; i++) begin
            a = base + addr_t'(i);
            blk[i*BEAT_W +: BEAT_W] = ref_mem[a % MEM_DEPTH];
        end
        return blk;
    endfunction

    task automatic store_block(input addr_t base, input block_t blk);
        addr_t a;
        for (int i = 0; i < 16; i++) begin
            a = base + addr_t'(i);
            ref_mem[a % MEM_DEPTH] = blk[i*BEAT_W +: BEAT_W];
        end
        ref_valid[base[9:4]] = 1'b1;
    endtask

    task automatic check_val(input block_t got, input block_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Reads are compared and writes stored in the model at their done.
    task automatic finish_xfer(input logic wr, input addr_t adr, input block_t blk,
                               input block_t got, input string side);
        if (wr) begin
            store_block(adr, blk);
        end else begin
            check_val(got, ref_block(adr), $sformatf("read block on engine %s", side));
        end
    endtask

    // Random block-aligned transfer.
    // A read of a block never written becomes a write.
    task automatic pick_xfer(output logic wr, output addr_t adr, output block_t blk);
        block_t bits;
        take_bits(7, bits);
        adr = addr_t'({bits[6:1], 4'b0000});
        wr  = bits[0] | ~ref_valid[bits[6:1]];
        take_bits(512, blk);
    endtask

    // Starts one or both engines in one cycle and waits for each done.
    task automatic run_pair(input logic go_a, input logic wr_a, input addr_t adr_a,
                            input block_t blk_a, input logic go_b, input logic wr_b,
                            input addr_t adr_b, input block_t blk_b);
        int   n;
        int   lat_a;
        int   lat_b;
        logic both;
        logic first_b;
        both    = go_a & go_b;
        // In a tie the engine not served last goes first.
        first_b = both ? ~last_b : go_b;
        n       = 0;
        lat_a   = 0;
        lat_b   = 0;
        @(posedge clk);
        i_start_read_a  <= go_a & ~wr_a;
        i_start_write_a <= go_a & wr_a;
        i_addr_a        <= adr_a;
        i_block_a       <= blk_a;
        i_start_read_b  <= go_b & ~wr_b;
        i_start_write_b <= go_b & wr_b;
        i_addr_b        <= adr_b;
        i_block_b       <= blk_b;
        @(posedge clk);
        i_start_read_a  <= 1'b0;
        i_start_write_a <= 1'b0;
        i_start_read_b  <= 1'b0;
        i_start_write_b <= 1'b0;
        while ((go_a && lat_a == 0) || (go_b && lat_b == 0)) begin
            @(posedge clk);
            n++;
            // Waiting engines stay busy until their done.
            if (go_a && lat_a == 0 && !o_done_a) begin
                check_val(block_t'(o_busy_a), block_t'(1), "busy low before done on engine A");
            end
            if (go_b && lat_b == 0 && !o_done_b) begin
                check_val(block_t'(o_busy_b), block_t'(1), "busy low before done on engine B");
            end
            if (o_done_a) begin
                check_val(block_t'(go_a && lat_a == 0), block_t'(1), "stray done on engine A");
                lat_a = n;
                finish_xfer(wr_a, adr_a, blk_a, o_block_a, "A");
            end
            if (o_done_b) begin
                check_val(block_t'(go_b && lat_b == 0), block_t'(1), "stray done on engine B");
                lat_b = n;
                finish_xfer(wr_b, adr_b, blk_b, o_block_b, "B");
            end
        end
        if (go_a) begin
            check_val(block_t'(lat_a), block_t'((both && first_b) ? LAT_SECOND : LAT_ALONE),
                      "done latency on engine A");
        end
        if (go_b) begin
            check_val(block_t'(lat_b), block_t'((both && !first_b) ? LAT_SECOND : LAT_ALONE),
                      "done latency on engine B");
        end
        last_b = both ? ~first_b : go_b;
    endtask

    // ---------------------------------------------------------------------
    // Tests.
    // ---------------------------------------------------------------------
    initial begin
        block_t blk_a;
        block_t blk_b;
        block_t old_blk;
        block_t bits;
        addr_t  adr_a;
        addr_t  adr_b;
        logic   wr_a;
        logic   wr_b;
        logic   a_first;
        int     n;
        clk             = 1'b0;
        i_rst_n         = 1'b0;
        i_start_read_a  = 1'b0;
        i_start_write_a = 1'b0;
        i_addr_a        = '0;
        i_block_a       = '0;
        i_start_read_b  = 1'b0;
        i_start_write_b = 1'b0;
        i_addr_b        = '0;
        i_block_b       = '0;
        lfsr_state      = 32'hac22;
        last_b          = 1'b1;
        ref_valid       = '0;
        cycle_cnt       = 0;
        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);
        check_val(block_t'({o_busy_a, o_busy_b, o_done_a, o_done_b}), '0, "outputs after reset");

        // Write then read back on A alone.
        take_bits(6, bits);
        adr_a = addr_t'({bits[5:0], 4'b0000});
        take_bits(512, blk_a);
        run_pair(1'b1, 1'b1, adr_a, blk_a, 1'b0, 1'b0, '0, '0);
        run_pair(1'b1, 1'b0, adr_a, '0, 1'b0, 1'b0, '0, '0);

        // Same on B in the next block.
        adr_b = adr_a ^ addr_t'(32'h10);
        take_bits(512, blk_b);
        run_pair(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, adr_b, blk_b);
        run_pair(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, adr_b, '0);

        // Tied writes on disjoint blocks and then tied reads across engines.
        adr_a = adr_a ^ addr_t'(32'h20);
        adr_b = adr_b ^ addr_t'(32'h20);
        take_bits(512, blk_a);
        take_bits(512, blk_b);
        run_pair(1'b1, 1'b1, adr_a, blk_a, 1'b1, 1'b1, adr_b, blk_b);
        run_pair(1'b1, 1'b0, adr_b, '0, 1'b1, 1'b0, adr_a, '0);

        // Writeback on A races a fill on B of the same block.
        // A goes first when B was served last.
        old_blk = ref_block(adr_a);
        a_first = last_b;
        take_bits(512, blk_a);
        run_pair(1'b1, 1'b1, adr_a, blk_a, 1'b1, 1'b0, adr_a, '0);
        check_val(o_block_b, a_first ? blk_a : old_blk, "fill racing a writeback");

        // Second start on a busy engine.
        take_bits(512, bits);
        @(posedge clk);
        i_start_read_a <= 1'b1;
        i_addr_a       <= adr_a;
        @(posedge clk);
        i_start_read_a <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n == 5) begin
                i_start_write_a <= 1'b1;
                i_addr_a        <= adr_b;
                i_block_a       <= bits;
            end
            if (n == 6) begin
                i_start_write_a <= 1'b0;
            end
        end while (!o_done_a);
        check_val(block_t'(n), block_t'(LAT_ALONE), "done latency with a dropped start");
        check_val(o_block_a, ref_block(adr_a), "read block with a dropped start");
        last_b = 1'b0;
        repeat (40) begin
            @(posedge clk);
            check_val(block_t'(o_done_a | o_busy_a), '0, "engine A ran a start given while busy");
        end
        run_pair(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, adr_b, '0);

        // Twenty random transfers in pairs.
        for (int r = 0; r < 10; r++) begin
            pick_xfer(wr_a, adr_a, blk_a);
            pick_xfer(wr_b, adr_b, blk_b);
            run_pair(1'b1, wr_a, adr_a, blk_a, 1'b1, wr_b, adr_b, blk_b);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== refill_subsystem_top.f ====
hw/cache_xfer_pkg.sv
hw/beat_sequencer.sv
hw/block_shift_buffer.sv
hw/cache_data_transfer.sv
hw/mem_port_arbiter.sv
hw/beat_memory.sv
hw/refill_subsystem_top.sv
sim/refill_tb.sv

// ==== Bender.yml ====
package:
  name: refill_subsystem

sources:
  # Package first, then the RTL bottom up.
  - files:
      - hw/cache_xfer_pkg.sv
      - hw/beat_sequencer.sv
      - hw/block_shift_buffer.sv
      - hw/cache_data_transfer.sv
      - hw/mem_port_arbiter.sv
      - hw/beat_memory.sv
      - hw/refill_subsystem_top.sv
  # Testbench, top module refill_tb.
  - target: simulation
    files:
      - sim/refill_tb.sv
